// File: design/procPkg.sv
// Shared widths, opcodes, ALU codes and bundle types for the 16-bit processor
// Modules pull this in with a wildcard import in their header
package procPkg;

	typedef logic [15:0] word_t;    // Data word, byte address or instruction
	typedef logic [2:0]  regIdx_t;
	typedef logic [4:0]  opcode_t;  // Instruction bits 15 to 11
	typedef logic [2:0]  aluOp_t;

	// Opcodes
	localparam opcode_t OP_HALT = 5'b00000;
	localparam opcode_t OP_J    = 5'b00100;
	localparam opcode_t OP_ADDI = 5'b01000;
	localparam opcode_t OP_ANDI = 5'b01011;
	localparam opcode_t OP_BEQZ = 5'b01100;
	localparam opcode_t OP_ST   = 5'b10000;
	localparam opcode_t OP_LD   = 5'b10001;
	localparam opcode_t OP_LBI  = 5'b11000;
	localparam opcode_t OP_RR   = 5'b11011;

	// Function field of OP_RR, bits 1 to 0
	localparam logic [1:0] FN_ADD = 2'b00;
	localparam logic [1:0] FN_SUB = 2'b01;
	localparam logic [1:0] FN_AND = 2'b10;
	localparam logic [1:0] FN_XOR = 2'b11;

	localparam aluOp_t ALU_ADD   = 3'd0;
	localparam aluOp_t ALU_SUB   = 3'd1;  // A minus B
	localparam aluOp_t ALU_AND   = 3'd2;
	localparam aluOp_t ALU_XOR   = 3'd3;
	localparam aluOp_t ALU_PASSB = 3'd4;

	// Destination field select
	localparam logic [1:0] DST_RT = 2'd0;  // Bits 7 to 5
	localparam logic [1:0] DST_RD = 2'd1;  // Bits 4 to 2
	localparam logic [1:0] DST_RS = 2'd2;  // Bits 10 to 8, LBI only since imm8 covers 7 to 0

	localparam logic [1:0] IMM_5S = 2'd0;
	localparam logic [1:0] IMM_5Z = 2'd1;
	localparam logic [1:0] IMM_8S = 2'd2;

	localparam logic [1:0] PC_SEQ  = 2'd0;
	localparam logic [1:0] PC_BEQZ = 2'd1;
	localparam logic [1:0] PC_JUMP = 2'd2;

	// Control bundle to the datapath
	typedef struct packed {
		logic       regWrite;
		logic [1:0] dstSel;
		logic       wbSel;     // 1 selects load data
		aluOp_t     aluOp;
		logic       bSrc;      // 1 selects the immediate
		logic [1:0] immSel;
		logic [1:0] pcSel;
		logic       pcWrite;
	} ctrl_t;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		word_t adr;
		word_t datW;
	} wbReq_t;

endpackage

// File: design/regFile.sv
// Eight 16-bit general registers
// Two combinational read ports and one write port on the clock edge
`timescale 1ns/1ns
module regFile
	import procPkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  regIdx_t rdSelA,
	input  regIdx_t rdSelB,
	input  regIdx_t wrSel,
	input  word_t   wrData,
	input  logic    wrEn,
	output word_t   rdA,
	output word_t   rdB
);

	word_t regs [8];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			regs <= '{default: '0};  // All registers start at zero
		else if (wrEn)
			regs[wrSel] <= wrData;
	end

	assign rdA = regs[rdSelA];  // Rs
	assign rdB = regs[rdSelB];  // Rt

	// Write data comes through ALU or bus, neither may carry X into state
	assert property (@(posedge clk) disable iff (!rstN)
		wrEn |-> !$isunknown(wrData));

endmodule

// File: design/execUnit.sv
// Immediate extender, B operand select and ALU
// Also gives the Rs zero test used by BEQZ
`timescale 1ns/1ns
module execUnit
	import procPkg::*;
(
	input  word_t instr,
	input  ctrl_t ctrl,
	input  word_t a,
	input  word_t b,
	output word_t result,
	output logic  isZero
);

	word_t imm;
	word_t bOp;

	always_comb begin
		case (ctrl.immSel)
			IMM_5Z:  imm = {11'b0, instr[4:0]};
			IMM_8S:  imm = {{8{instr[7]}}, instr[7:0]};
			default: imm = {{11{instr[4]}}, instr[4:0]};  // IMM_5S, also LD/ST offset
		endcase
	end

	assign bOp = ctrl.bSrc ? imm : b;

	always_comb begin
		case (ctrl.aluOp)
			ALU_ADD:   result = a + bOp;
			ALU_SUB:   result = a - bOp;  // Rs minus Rt
			ALU_AND:   result = a & bOp;
			ALU_XOR:   result = a ^ bOp;
			ALU_PASSB: result = bOp;      // LBI
			default:   result = '0;
		endcase
	end

	assign isZero = (a == '0);

endmodule

// File: design/pcLogic.sv
// Program counter and next-PC select
// Byte addressed, targets are relative to PC plus 2
`timescale 1ns/1ns
module pcLogic
	import procPkg::*;
(
	input  logic  clk,
	input  logic  rstN,
	input  word_t instr,
	input  ctrl_t ctrl,
	input  logic  isZero,
	output word_t pc
);

	word_t pcPlus2, brTarget, jTarget, nextPc;

	assign pcPlus2  = pc + 16'd2;
	assign brTarget = pcPlus2 + {{7{instr[7]}}, instr[7:0], 1'b0};    // Twice signed imm8
	assign jTarget  = pcPlus2 + {{4{instr[10]}}, instr[10:0], 1'b0};  // Twice signed disp11

	always_comb begin
		case (ctrl.pcSel)
			PC_SEQ:  nextPc = pcPlus2;
			PC_BEQZ: nextPc = isZero ? brTarget : pcPlus2;
			PC_JUMP: nextPc = jTarget;
			default: nextPc = pcPlus2;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= '0;
		else if (ctrl.pcWrite)
			pc <= nextPc;
	end

endmodule

// File: design/wbMaster.sv
// Wishbone classic master shared by instruction fetch and data access
// Holds the instruction register and the load data latch
`timescale 1ns/1ns
module wbMaster
	import procPkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  logic   busFetch,
	input  logic   busMem,
	input  logic   memWrite,
	input  word_t  pc,
	input  word_t  dataAdr,
	input  word_t  storeData,
	output wbReq_t req,
	input  word_t  datR,
	input  logic   ack,
	output logic   busDone,
	output word_t  instr,
	output word_t  loadData
);

	logic start;

	assign start   = (busFetch || busMem) && !req.cyc;
	assign busDone = req.cyc && ack;  // Requester advances on this edge

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			req <= '0;
		end else if (start) begin
			req.cyc  <= 1'b1;
			req.stb  <= 1'b1;
			req.we   <= busMem && memWrite;
			req.adr  <= busMem ? dataAdr : pc;
			req.datW <= storeData;
		end else if (busDone) begin
			req.cyc <= 1'b0;  // Drop the cycle after the ack edge
			req.stb <= 1'b0;
			req.we  <= 1'b0;
		end
	end

	// Read data latches, captured at the ack edge
	always_ff @(posedge clk) begin
		if (busDone && busFetch)
			instr <= datR;
		if (busDone && busMem && !req.we)
			loadData <= datR;
	end

	assert property (@(posedge clk) disable iff (!rstN) req.stb |-> req.cyc);

	// Request must not move while the slave stalls
	assert property (@(posedge clk) disable iff (!rstN)
		(req.stb && !ack) |=> ($stable(req.adr) && $stable(req.we)));

endmodule

// File: design/procControl.sv
// Multi-cycle sequencer and instruction decoder
// Drives the datapath control bundle and requests bus cycles from the master
`timescale 1ns/1ns
module procControl
	import procPkg::*;
(
	input  logic  clk,
	input  logic  rstN,
	input  word_t instr,
	input  logic  busDone,
	output ctrl_t ctrl,
	output logic  busFetch,
	output logic  busMem,
	output logic  memWrite,
	output logic  halted,
	output logic  err
);

	typedef enum logic [2:0] {FETCH, DECODE, EXEC, MEM, WB, HALT, ERROR} state_t;

	state_t  state, nextState;
	ctrl_t   dec;
	opcode_t opcode;
	logic    legal, isLoad, isStore, isHaltOp;

	assign opcode = instr[15:11];

	// Opcode decode, independent of state
	always_comb begin
		dec.regWrite = 1'b0;  // Means "writes in EXEC" here, masked below
		dec.dstSel   = DST_RT;
		dec.wbSel    = 1'b0;
		dec.aluOp    = ALU_ADD;
		dec.bSrc     = 1'b0;
		dec.immSel   = IMM_5S;
		dec.pcSel    = PC_SEQ;
		dec.pcWrite  = 1'b0;
		legal    = 1'b1;
		isLoad   = 1'b0;
		isStore  = 1'b0;
		isHaltOp = 1'b0;
		case (opcode)
			OP_HALT: isHaltOp = 1'b1;
			OP_LBI: begin
				dec.regWrite = 1'b1;
				dec.dstSel   = DST_RS;
				dec.aluOp    = ALU_PASSB;
				dec.bSrc     = 1'b1;
				dec.immSel   = IMM_8S;
			end
			OP_ADDI: begin
				dec.regWrite = 1'b1;
				dec.bSrc     = 1'b1;
			end
			OP_ANDI: begin
				dec.regWrite = 1'b1;
				dec.aluOp    = ALU_AND;
				dec.bSrc     = 1'b1;
				dec.immSel   = IMM_5Z;  // Mask immediate is zero extended
			end
			OP_RR: begin
				dec.regWrite = 1'b1;
				dec.dstSel   = DST_RD;
				case (instr[1:0])
					FN_ADD:  dec.aluOp = ALU_ADD;
					FN_SUB:  dec.aluOp = ALU_SUB;
					FN_AND:  dec.aluOp = ALU_AND;
					FN_XOR:  dec.aluOp = ALU_XOR;
					default: dec.aluOp = ALU_ADD;
				endcase
			end
			OP_LD: begin
				isLoad    = 1'b1;
				dec.wbSel = 1'b1;
				dec.bSrc  = 1'b1;  // Address is Rs plus signed imm5
			end
			OP_ST: begin
				isStore  = 1'b1;
				dec.bSrc = 1'b1;
			end
			OP_BEQZ: dec.pcSel = PC_BEQZ;
			OP_J:    dec.pcSel = PC_JUMP;
			default: legal = 1'b0;
		endcase
	end

	// Per-state strobes and next state
	always_comb begin
		ctrl          = dec;
		ctrl.regWrite = 1'b0;
		ctrl.pcWrite  = 1'b0;
		busFetch      = 1'b0;
		busMem        = 1'b0;
		memWrite      = 1'b0;
		nextState     = state;
		case (state)
			FETCH: begin
				busFetch = 1'b1;
				if (busDone)
					nextState = DECODE;
			end
			DECODE: begin
				if (!legal)
					nextState = ERROR;
				else if (isHaltOp)
					nextState = HALT;
				else
					nextState = EXEC;
			end
			EXEC: begin
				if (isLoad || isStore) begin
					nextState = MEM;
				end else begin
					ctrl.regWrite = dec.regWrite;
					ctrl.pcWrite  = 1'b1;
					nextState     = FETCH;
				end
			end
			MEM: begin
				busMem   = 1'b1;
				memWrite = isStore;
				if (busDone) begin
					if (isLoad) begin
						nextState = WB;
					end else begin
						ctrl.pcWrite = 1'b1;  // Store retires here
						nextState    = FETCH;
					end
				end
			end
			WB: begin
				ctrl.regWrite = 1'b1;
				ctrl.pcWrite  = 1'b1;
				nextState     = FETCH;
			end
			default: nextState = state;  // HALT and ERROR hold
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			state <= FETCH;
		else
			state <= nextState;
	end

	assign halted = (state == HALT);
	assign err    = (state == ERROR);

	// No architectural update while an instruction is being fetched
	assert property (@(posedge clk) disable iff (!rstN)
		busFetch |-> !(ctrl.pcWrite || ctrl.regWrite));

endmodule

// File: design/procTop.sv
// Processor top level with control, datapath and one Wishbone master port
// Instruction and data memory sit outside and answer on the bus
`timescale 1ns/1ns
module procTop
	import procPkg::*;
(
	input  logic  clk,
	input  logic  rstN,
	output logic  cyc,
	output logic  stb,
	output logic  we,
	output word_t adr,
	output word_t datW,
	input  word_t datR,
	input  logic  ack,
	output logic  halted,
	output logic  err
);

	ctrl_t   ctrl;
	wbReq_t  req;
	word_t   instr;
	word_t   loadData;
	word_t   rdA, rdB;
	word_t   result;
	word_t   pc;
	word_t   wrData;
	regIdx_t wrSel;
	logic    busFetch, busMem, memWrite, busDone;
	logic    isZero;

	// Write-back destination and data
	assign wrSel = (ctrl.dstSel == DST_RD) ? instr[4:2] :
		(ctrl.dstSel == DST_RS) ? instr[10:8] : instr[7:5];
	assign wrData = ctrl.wbSel ? loadData : result;

	assign cyc  = req.cyc;
	assign stb  = req.stb;
	assign we   = req.we;
	assign adr  = req.adr;
	assign datW = req.datW;

	procControl procControl_inst (.clk(clk), .rstN(rstN), .instr(instr), .busDone(busDone),
		.ctrl(ctrl), .busFetch(busFetch), .busMem(busMem), .memWrite(memWrite),
		.halted(halted), .err(err));

	regFile regFile_inst (.clk(clk), .rstN(rstN), .rdSelA(instr[10:8]), .rdSelB(instr[7:5]),
		.wrSel(wrSel), .wrData(wrData), .wrEn(ctrl.regWrite), .rdA(rdA), .rdB(rdB));

	execUnit execUnit_inst (.instr(instr), .ctrl(ctrl), .a(rdA), .b(rdB), .result(result),
		.isZero(isZero));

	pcLogic pcLogic_inst (.clk(clk), .rstN(rstN), .instr(instr), .ctrl(ctrl),
		.isZero(isZero), .pc(pc));

	// Store data is always the Rt field register
	wbMaster wbMaster_inst (.clk(clk), .rstN(rstN), .busFetch(busFetch), .busMem(busMem),
		.memWrite(memWrite), .pc(pc), .dataAdr(result), .storeData(rdB), .req(req),
		.datR(datR), .ack(ack), .busDone(busDone), .instr(instr), .loadData(loadData));

endmodule

// File: bench/wbMemory.sv
// Wishbone classic memory model for the processor testbench, 256 words, byte addressed
// Adds random wait states, takes a program through a backdoor load, logs the last store
`timescale 1ns/1ns
module wbMemory
	import procPkg::*;
(
	input  logic         clk,
	input  logic         load,        // Refill memory and clear the log, held during reset
	input  word_t [11:0] prog,
	input  logic         slow,        // Three wait states on every cycle
	input  logic         cyc,
	input  logic         stb,
	input  logic         we,
	input  word_t        adr,
	input  word_t        datW,
	output word_t        datR,
	output logic         ack,
	output int           storeCount,
	output int           busCount,
	output word_t        lastStAdr,
	output word_t        lastStData
);

	word_t      mem [256];
	integer     seed = 59596;
	logic [1:0] waitTarget = 2'd0;
	logic [1:0] waitCnt = 2'd0;
	logic       ackQ = 1'b0;
	word_t      datQ = 16'h0000;

	assign ack  = ackQ;
	assign datR = datQ;

	// Responses change on the falling edge, the DUT samples them on the rising one
	always @(negedge clk) begin
		ackQ <= 1'b0;
		if (load) begin
			for (int i = 0; i < 256; i++) begin
				if (i < 12)
					mem[i] <= prog[i];
				else
					mem[i] <= word_t'((i * 257) ^ 16'hC3A5);  // Unique per word
			end
			storeCount <= 0;
			busCount   <= 0;
			lastStAdr  <= '0;
			lastStData <= '0;
			waitCnt    <= '0;
		end else if (cyc && stb && !ackQ) begin
			if (waitCnt == (slow ? 2'd3 : waitTarget)) begin
				ackQ       <= 1'b1;
				waitCnt    <= '0;
				waitTarget <= 2'($random(seed));  // Wait states of the next cycle
				busCount   <= busCount + 1;
				if (we) begin
					mem[adr[8:1]] <= datW;
					storeCount    <= storeCount + 1;
					lastStAdr     <= adr;
					lastStData    <= datW;
				end else begin
					datQ <= mem[adr[8:1]];
				end
			end else begin
				waitCnt <= waitCnt + 2'd1;
			end
		end
	end

endmodule

// File: bench/procTb.sv
// Table-driven test of the processor with programs run from the Wishbone memory model
// Each row resets the DUT, loads a program, runs it to halt or error and checks the stores
`timescale 1ns/1ns
module procTb
	import procPkg::*;
();

	localparam int NUM_ROWS = 18;
	// Up to 12 instructions of 12 cycles each, plus reset and idle check per row
	localparam int CYCLE_LIMIT = NUM_ROWS * (12 * 12 + 16);

	typedef struct packed {
		logic       err;
		word_t      stAdr;   // Last store
		word_t      stData;
		logic [7:0] stCount;
	} expect_t;

	logic         clk = 1'b0;
	logic         rstN, load, slow;
	word_t [11:0] prog;
	logic         cyc, stb, we, ack, halted, err;
	word_t        adr, datW, datR;
	int           storeCount, busCount;
	word_t        lastStAdr, lastStData;

	string        names [NUM_ROWS];
	word_t [11:0] progs [NUM_ROWS];
	expect_t      expects [NUM_ROWS];
	logic         slowRows [NUM_ROWS];
	string        opNames [6] = '{"add", "sub", "and", "xor", "addi", "andi"};
	int           rowCount = 0;
	int           errors = 0;
	int           failedTests = 0;
	int           cycles = 0;
	integer       seed = 59596;
	logic [7:0]   opA, opB;  // Random LBI operands
	logic [4:0]   opImm;

	always #10 clk = ~clk;

	procTop procTop_inst (.clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.datW(datW), .datR(datR), .ack(ack), .halted(halted), .err(err));

	wbMemory wbMemory_inst (.clk(clk), .load(load), .prog(prog), .slow(slow), .cyc(cyc),
		.stb(stb), .we(we), .adr(adr), .datW(datW), .datR(datR), .ack(ack),
		.storeCount(storeCount), .busCount(busCount), .lastStAdr(lastStAdr),
		.lastStData(lastStData));

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	// Instruction encoders, fields as in the ISA
	function automatic word_t encI(opcode_t op, regIdx_t rs, regIdx_t rt, logic [4:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encR(regIdx_t rs, regIdx_t rt, regIdx_t rd, logic [1:0] fn);
		return {OP_RR, rs, rt, rd, fn};
	endfunction

	function automatic word_t encL(opcode_t op, regIdx_t rs, logic [7:0] imm);  // LBI, BEQZ
		return {op, rs, imm};
	endfunction

	function automatic word_t encJ(logic [10:0] disp);
		return {OP_J, disp};
	endfunction

	function automatic word_t arithInstr(int kind);
		case (kind)
			0: return encR(3'd1, 3'd2, 3'd3, FN_ADD);
			1: return encR(3'd1, 3'd2, 3'd3, FN_SUB);
			2: return encR(3'd1, 3'd2, 3'd3, FN_AND);
			3: return encR(3'd1, 3'd2, 3'd3, FN_XOR);
			4: return encI(OP_ADDI, 3'd1, 3'd3, opImm);
			default: return encI(OP_ANDI, 3'd1, 3'd3, opImm);
		endcase
	endfunction

	function automatic word_t arithResult(int kind, word_t x, word_t y);
		case (kind)
			0: return x + y;
			1: return x - y;  // Rs minus Rt
			2: return x & y;
			3: return x ^ y;
			4: return x + {{11{opImm[4]}}, opImm};
			default: return x & {11'b0, opImm};  // ANDI mask is zero extended
		endcase
	endfunction

	task automatic addRow(string name, word_t [11:0] p, logic e, word_t a, word_t d,
		logic [7:0] n, logic s);
		names[rowCount]    = name;
		progs[rowCount]    = p;
		expects[rowCount]  = {e, a, d, n};
		slowRows[rowCount] = s;
		rowCount++;
	endtask

	task automatic addArith(int kind, logic s);
		word_t [11:0] p;
		word_t x, y;
		p    = '0;  // Unused words read as HALT
		x    = {{8{opA[7]}}, opA};
		y    = {{8{opB[7]}}, opB};
		p[0] = encL(OP_LBI, 3'd1, opA);
		p[1] = encL(OP_LBI, 3'd2, opB);
		p[2] = encL(OP_LBI, 3'd4, 8'h40);  // Store base
		p[3] = arithInstr(kind);
		p[4] = encI(OP_ST, 3'd4, 3'd3, 5'd2);
		addRow(s ? {"slow_", opNames[kind]} : opNames[kind], p, 1'b0, 16'h0042,
			arithResult(kind, x, y), 8'd1, s);
	endtask

	task automatic buildTable();
		word_t [11:0] p;
		for (int k = 0; k < 6; k++)
			addArith(k, 1'b0);
		p    = '0;
		p[0] = encL(OP_LBI, 3'd1, 8'h50);
		p[1] = encL(OP_LBI, 3'd2, 8'hA5);
		p[2] = encI(OP_ST, 3'd1, 3'd2, 5'h1C);  // Offset -4, address 0x4C
		p[3] = encI(OP_LD, 3'd1, 3'd5, 5'h1C);
		p[4] = encI(OP_ST, 3'd1, 3'd5, 5'h1C);
		addRow("ldst", p, 1'b0, 16'h004C, 16'hFFA5, 8'd2, 1'b0);
		// Taken branch at PC 2 lands on 2 + 2 + 2*2 = 8, word 4
		p    = '0;
		p[0] = encL(OP_LBI, 3'd4, 8'h40);
		p[1] = encL(OP_BEQZ, 3'd0, 8'd2);
		p[2] = encI(OP_ST, 3'd4, 3'd4, 5'd0);
		p[3] = encI(OP_ST, 3'd4, 3'd4, 5'd2);
		p[4] = encL(OP_LBI, 3'd1, 8'h11);
		p[5] = encI(OP_ST, 3'd4, 3'd1, 5'd4);
		addRow("beqz_taken", p, 1'b0, 16'h0044, 16'h0011, 8'd1, 1'b0);
		p    = '0;
		p[0] = encL(OP_LBI, 3'd4, 8'h40);
		p[1] = encL(OP_BEQZ, 3'd4, 8'd1);  // r4 nonzero, falls through
		p[2] = encI(OP_ST, 3'd4, 3'd4, 5'd0);
		p[3] = encL(OP_LBI, 3'd1, 8'h22);
		p[4] = encI(OP_ST, 3'd4, 3'd1, 5'd4);
		addRow("beqz_fall", p, 1'b0, 16'h0044, 16'h0022, 8'd2, 1'b0);
		p    = '0;
		p[0] = encL(OP_LBI, 3'd4, 8'h40);
		p[1] = encJ(11'd1);                    // 2 + 2 + 2*1 = 6, word 3
		p[2] = encI(OP_ST, 3'd4, 3'd4, 5'd0);
		p[3] = encI(OP_ST, 3'd4, 3'd4, 5'd6);
		addRow("jump", p, 1'b0, 16'h0046, 16'h0040, 8'd1, 1'b0);
		p    = '0;
		p[0] = encL(OP_LBI, 3'd1, 8'h05);
		p[2] = encI(OP_ST, 3'd0, 3'd1, 5'd8);  // Behind HALT, never runs
		addRow("halt", p, 1'b0, 16'h0000, 16'h0000, 8'd0, 1'b0);
		p    = '0;
		p[0] = encL(OP_LBI, 3'd4, 8'h40);
		p[1] = encI(OP_ST, 3'd4, 3'd4, 5'd0);
		p[2] = 16'hF800;                       // Opcode 11111 is undefined
		p[3] = encI(OP_ST, 3'd4, 3'd4, 5'd2);
		addRow("illegal", p, 1'b1, 16'h0040, 16'h0040, 8'd1, 1'b0);
		for (int k = 0; k < 6; k++)
			addArith(k, 1'b1);
	endtask

	task automatic checkValue(string testName, string what, logic [31:0] expected,
		logic [31:0] actual);
		if (actual !== expected) begin
			$display("error %s: %s expected %h actual %h", testName, what, expected, actual);
			errors++;
		end
	endtask

	task automatic runRow(int r);
		int busBefore;
		int errBefore;
		@(negedge clk);
		rstN = 1'b0;
		load = 1'b1;  // Reloading is harmless, so it stays high through reset
		prog = progs[r];
		slow = slowRows[r];
		repeat (8) @(negedge clk);
		rstN = 1'b1;
		load = 1'b0;
		while (!(halted || err))
			@(negedge clk);
		busBefore = busCount;
		repeat (4) @(negedge clk);
		errBefore = errors;
		checkValue(names[r], "err", 32'(expects[r].err), 32'(err));
		checkValue(names[r], "halted", 32'(!expects[r].err), 32'(halted));
		checkValue(names[r], "store count", 32'(expects[r].stCount), 32'(storeCount));
		checkValue(names[r], "store address", 32'(expects[r].stAdr), 32'(lastStAdr));
		checkValue(names[r], "store data", 32'(expects[r].stData), 32'(lastStData));
		checkValue(names[r], "bus cycles after finish", 32'(busBefore), 32'(busCount));
		checkValue(names[r], "cyc after finish", 32'(0), 32'(cyc));
		checkValue(names[r], "stb after finish", 32'(0), 32'(stb));
		if (errors == errBefore) begin
			$display("%s passed", names[r]);
		end else begin
			$display("%s failed", names[r]);
			failedTests++;
		end
	endtask

	initial begin
		rstN  = 1'b0;
		load  = 1'b0;
		slow  = 1'b0;
		prog  = '0;
		opA   = 8'($random(seed));
		opB   = 8'($random(seed));
		opImm = 5'($random(seed));
		buildTable();
		for (int r = 0; r < rowCount; r++)
			runRow(r);
		$display("tests %0d, failed %0d, errors %0d", rowCount, failedTests, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: all.f
design/procPkg.sv
design/regFile.sv
design/execUnit.sv
design/pcLogic.sv
design/wbMaster.sv
design/procControl.sv
design/procTop.sv
bench/wbMemory.sv
bench/procTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = procTb
FILELIST = all.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '>>> FAIL' $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	grep -q '>>> PASS' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
